/* src/udp_rx_consts.svh */
// Sizing for the receive dispatch stage
// UDP_RX_SEL_W must stay equal to clog2(UDP_RX_OUTPUTS)
`ifndef UDP_RX_CONSTS_SVH
`define UDP_RX_CONSTS_SVH

// Output streams, one port-table entry each
`define UDP_RX_OUTPUTS 4

// Output index width
`define UDP_RX_SEL_W 2

// Payload is byte wide, no tkeep
`define UDP_RX_DATA_W 8

`define UDP_RX_PORT_W 16

// Statistics counters saturate at all ones
`define UDP_RX_CNT_W 16

`endif

/* src/udp_rx_pkg.sv */
// Types shared by the classifier, demux and top level of the receive stage

`default_nettype none

package udp_rx_pkg;

    // Frame state of the demux
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,  // Waiting for a header
        ST_FORWARD = 2'd1,  // Payload steered to the selected output
        ST_DISCARD = 2'd2   // Payload consumed and thrown away
    } demux_state_t;

    // Port lookup verdict, a miss means drop
    typedef enum logic {
        CLASS_HIT  = 1'b0,
        CLASS_MISS = 1'b1
    } class_result_t;

endpackage

`default_nettype wire

/* src/udp_port_classifier.sv */
// Entries come out of reset disabled; the lowest enabled matching entry wins
// Lookup is combinational on dest_port, so the result is only valid alongside it
`include "udp_rx_consts.svh"

`default_nettype none

module udp_port_classifier (
    input var logic                         clk,
    input var logic                         rst_n,

    input var logic                         cfg_wr,
    input var logic [`UDP_RX_SEL_W-1:0]     cfg_index,
    input var logic [`UDP_RX_PORT_W-1:0]    cfg_port,
    input var logic                         cfg_en,

    input var logic [`UDP_RX_PORT_W-1:0]    dest_port,
    output udp_rx_pkg::class_result_t       result,
    output var logic [`UDP_RX_SEL_W-1:0]    select
);
    import udp_rx_pkg::*;

    localparam int OUTPUTS = `UDP_RX_OUTPUTS;
    localparam int SEL_W   = `UDP_RX_SEL_W;

    logic [`UDP_RX_PORT_W-1:0] port_tab [OUTPUTS];
    logic [OUTPUTS-1:0]        port_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_en <= '0;
        end else if (cfg_wr) begin
            port_en[cfg_index] <= cfg_en;
        end
    end

    // Port numbers only matter once the entry is enabled
    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            port_tab[cfg_index] <= cfg_port;
        end
    end

    // Scan from the top so the lowest matching index is the last one written
    always_comb begin
        result = CLASS_MISS;
        select = '0;
        for (int i = OUTPUTS - 1; i >= 0; i--) begin
            if (port_en[i] && (port_tab[i] == dest_port)) begin
                result = CLASS_HIT;
                select = SEL_W'(i);
            end
        end
    end

    // A hit points at an enabled entry that really holds this port
    a_hit_enabled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (result == CLASS_HIT) |-> (port_en[select] && (port_tab[select] == dest_port))
    ) else $error("Classifier hit on disabled or mismatching entry %0d", select);

endmodule

`default_nettype wire

/* src/udp_rx_demux.sv */
// One header accepted per frame; a new one waits for ST_IDLE and the last output header taken
// Payload passes with zero latency in ST_FORWARD and is swallowed in ST_DISCARD
`include "udp_rx_consts.svh"

`default_nettype none

module udp_rx_demux (
    input var logic                         clk,
    input var logic                         rst_n,
    input var logic                         rx_enable,

    input var udp_rx_pkg::class_result_t    cls_result,
    input var logic [`UDP_RX_SEL_W-1:0]     cls_select,

    input var logic                         in_hdr_valid,
    output var logic                        in_hdr_ready,
    input var logic [31:0]                  in_src_ip,
    input var logic [15:0]                  in_src_port,
    input var logic [15:0]                  in_dest_port,
    input var logic [15:0]                  in_udp_length,

    input var logic [`UDP_RX_DATA_W-1:0]    in_tdata,
    input var logic                         in_tvalid,
    output var logic                        in_tready,
    input var logic                         in_tlast,

    output var logic [`UDP_RX_OUTPUTS-1:0]  out_hdr_valid,
    input var logic [`UDP_RX_OUTPUTS-1:0]   out_hdr_ready,
    output var logic [31:0]                 out_src_ip,
    output var logic [15:0]                 out_src_port,
    output var logic [15:0]                 out_dest_port,
    output var logic [15:0]                 out_udp_length,

    output var logic [`UDP_RX_DATA_W-1:0]   out_tdata,
    output var logic [`UDP_RX_OUTPUTS-1:0]  out_tvalid,
    input var logic [`UDP_RX_OUTPUTS-1:0]   out_tready,
    output var logic                        out_tlast,

    output var logic                        frame_done,
    output var logic [`UDP_RX_SEL_W-1:0]    frame_out,
    output var logic                        frame_dropped
);
    import udp_rx_pkg::*;

    localparam int OUTPUTS = `UDP_RX_OUTPUTS;
    localparam int SEL_W   = `UDP_RX_SEL_W;

    demux_state_t     state;
    logic [SEL_W-1:0] sel_q;
    logic             drop_q;
    logic             hdr_pend;     // Output header waiting for its ready

    logic hdr_xfer;
    logic out_hdr_xfer;
    logic last_xfer;

    assign in_hdr_ready = (state == ST_IDLE) && !hdr_pend && rx_enable;
    assign hdr_xfer     = in_hdr_valid && in_hdr_ready;
    assign out_hdr_xfer = hdr_pend && out_hdr_ready[sel_q];
    assign last_xfer    = in_tvalid && in_tready && in_tlast;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            hdr_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= (cls_result == CLASS_HIT) ? ST_FORWARD : ST_DISCARD;
                    end
                end
                ST_FORWARD, ST_DISCARD: begin
                    if (last_xfer) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase

            // Accept is blocked while pending, so set and clear never coincide
            if (hdr_xfer && (cls_result == CLASS_HIT)) begin
                hdr_pend <= 1'b1;
            end else if (out_hdr_xfer) begin
                hdr_pend <= 1'b0;
            end
        end
    end

    // Frame fields held for the whole frame
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            sel_q          <= cls_select;
            drop_q         <= (cls_result == CLASS_MISS);
            out_src_ip     <= in_src_ip;
            out_src_port   <= in_src_port;
            out_dest_port  <= in_dest_port;
            out_udp_length <= in_udp_length;
        end
    end

    always_comb begin
        for (int i = 0; i < OUTPUTS; i++) begin
            out_hdr_valid[i] = hdr_pend && (sel_q == SEL_W'(i));
            out_tvalid[i]    = (state == ST_FORWARD) && (sel_q == SEL_W'(i)) && in_tvalid;
        end
    end

    always_comb begin
        case (state)
            ST_FORWARD: in_tready = out_tready[sel_q];
            ST_DISCARD: in_tready = 1'b1;
            default:    in_tready = 1'b0;
        endcase
    end

    assign out_tdata = in_tdata;
    assign out_tlast = in_tlast;

    assign frame_done    = last_xfer;
    assign frame_out     = sel_q;
    assign frame_dropped = drop_q;

    a_hdr_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(out_hdr_valid)
    ) else $error("More than one output header valid: %b", out_hdr_valid);

    a_tvalid_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(out_tvalid)
    ) else $error("More than one output tvalid: %b", out_tvalid);

    for (genvar i = 0; i < OUTPUTS; i++) begin : g_hold
        // Header stays up with stable fields until the sink takes it
        a_hdr_hold: assert property (
            @(posedge clk) disable iff (!rst_n)
            (out_hdr_valid[i] && !out_hdr_ready[i]) |=>
                (out_hdr_valid[i] && $stable(out_src_ip) && $stable(out_src_port) &&
                 $stable(out_dest_port) && $stable(out_udp_length))
        ) else $error("Output %0d header dropped or changed before ready", i);
    end

endmodule

`default_nettype wire

/* src/udp_rx_counters.sv */
// Counters saturate rather than wrap
// stat_index 0..OUTPUTS-1 reads delivered frames, OUTPUTS reads drops, others read zero
`include "udp_rx_consts.svh"

`default_nettype none

module udp_rx_counters (
    input var logic                         clk,
    input var logic                         rst_n,

    input var logic                         frame_done,
    input var logic [`UDP_RX_SEL_W-1:0]     frame_out,
    input var logic                         frame_dropped,

    input var logic [`UDP_RX_SEL_W:0]       stat_index,
    output var logic [`UDP_RX_CNT_W-1:0]    stat_count
);
    localparam int OUTPUTS = `UDP_RX_OUTPUTS;
    localparam int SEL_W   = `UDP_RX_SEL_W;
    localparam int CNT_W   = `UDP_RX_CNT_W;

    logic [CNT_W-1:0] deliv_cnt [OUTPUTS];
    logic [CNT_W-1:0] drop_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < OUTPUTS; i++) begin
                deliv_cnt[i] <= '0;
            end
            drop_cnt <= '0;
        end else if (frame_done) begin
            if (frame_dropped) begin
                if (drop_cnt != '1) drop_cnt <= drop_cnt + 1'b1;
            end else if (deliv_cnt[frame_out] != '1) begin
                deliv_cnt[frame_out] <= deliv_cnt[frame_out] + 1'b1;
            end
        end
    end

    always_comb begin
        stat_count = '0;
        if (int'(stat_index) < OUTPUTS) begin
            stat_count = deliv_cnt[stat_index[SEL_W-1:0]];
        end else if (int'(stat_index) == OUTPUTS) begin
            stat_count = drop_cnt;
        end
    end

endmodule

`default_nettype wire

/* src/udp_rx_dispatch_top.sv */
// Receive dispatch stage: port lookup, frame steering and statistics
// Ports are configured after reset; until then every frame is dropped
`include "udp_rx_consts.svh"

`default_nettype none

module udp_rx_dispatch_top (
    input var logic                         clk,
    input var logic                         rst_n,
    input var logic                         rx_enable,

    input var logic                         cfg_wr,
    input var logic [`UDP_RX_SEL_W-1:0]     cfg_index,
    input var logic [`UDP_RX_PORT_W-1:0]    cfg_port,
    input var logic                         cfg_en,

    input var logic                         in_hdr_valid,
    output var logic                        in_hdr_ready,
    input var logic [31:0]                  in_src_ip,
    input var logic [15:0]                  in_src_port,
    input var logic [15:0]                  in_dest_port,
    input var logic [15:0]                  in_udp_length,

    input var logic [`UDP_RX_DATA_W-1:0]    in_tdata,
    input var logic                         in_tvalid,
    output var logic                        in_tready,
    input var logic                         in_tlast,

    output var logic [`UDP_RX_OUTPUTS-1:0]  out_hdr_valid,
    input var logic [`UDP_RX_OUTPUTS-1:0]   out_hdr_ready,
    output var logic [31:0]                 out_src_ip,
    output var logic [15:0]                 out_src_port,
    output var logic [15:0]                 out_dest_port,
    output var logic [15:0]                 out_udp_length,

    output var logic [`UDP_RX_DATA_W-1:0]   out_tdata,
    output var logic [`UDP_RX_OUTPUTS-1:0]  out_tvalid,
    input var logic [`UDP_RX_OUTPUTS-1:0]   out_tready,
    output var logic                        out_tlast,

    input var logic [`UDP_RX_SEL_W:0]       stat_index,
    output var logic [`UDP_RX_CNT_W-1:0]    stat_count
);
    import udp_rx_pkg::*;

    class_result_t              cls_result;
    logic [`UDP_RX_SEL_W-1:0]   cls_select;

    logic                       frame_done;
    logic [`UDP_RX_SEL_W-1:0]   frame_out;
    logic                       frame_dropped;

    // Looks at the header still sitting on the input
    udp_port_classifier u_classifier (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_index (cfg_index),
        .cfg_port  (cfg_port),
        .cfg_en    (cfg_en),
        .dest_port (in_dest_port),
        .result    (cls_result),
        .select    (cls_select)
    );

    udp_rx_demux u_demux (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_enable      (rx_enable),
        .cls_result     (cls_result),
        .cls_select     (cls_select),
        .in_hdr_valid   (in_hdr_valid),
        .in_hdr_ready   (in_hdr_ready),
        .in_src_ip      (in_src_ip),
        .in_src_port    (in_src_port),
        .in_dest_port   (in_dest_port),
        .in_udp_length  (in_udp_length),
        .in_tdata       (in_tdata),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tlast       (in_tlast),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_src_ip     (out_src_ip),
        .out_src_port   (out_src_port),
        .out_dest_port  (out_dest_port),
        .out_udp_length (out_udp_length),
        .out_tdata      (out_tdata),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .out_tlast      (out_tlast),
        .frame_done     (frame_done),
        .frame_out      (frame_out),
        .frame_dropped  (frame_dropped)
    );

    udp_rx_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame_done    (frame_done),
        .frame_out     (frame_out),
        .frame_dropped (frame_dropped),
        .stat_index    (stat_index),
        .stat_count    (stat_count)
    );

endmodule

`default_nettype wire

/* tests/udp_rx_checker.sv */
// Keeps its own port table from cfg writes and expects one output per frame
// Model state is only valid after the first reset
`include "udp_rx_consts.svh"

module udp_rx_checker (
    input logic                         clk, rst_n, rx_enable,
    input logic                         cfg_wr, cfg_en,
    input logic [`UDP_RX_SEL_W-1:0]     cfg_index,
    input logic [`UDP_RX_PORT_W-1:0]    cfg_port,
    input logic                         in_hdr_valid, in_hdr_ready,
    input logic [31:0]                  in_src_ip,
    input logic [15:0]                  in_src_port, in_dest_port, in_udp_length,
    input logic [`UDP_RX_DATA_W-1:0]    in_tdata,
    input logic                         in_tvalid, in_tready, in_tlast,
    input logic [`UDP_RX_OUTPUTS-1:0]   out_hdr_valid, out_hdr_ready,
    input logic [31:0]                  out_src_ip,
    input logic [15:0]                  out_src_port, out_dest_port, out_udp_length,
    input logic [`UDP_RX_DATA_W-1:0]    out_tdata,
    input logic [`UDP_RX_OUTPUTS-1:0]   out_tvalid, out_tready,
    input logic                         out_tlast,
    input logic [`UDP_RX_SEL_W:0]       stat_index,
    input logic [`UDP_RX_CNT_W-1:0]     stat_count,
    input logic                         stat_strobe, end_check,
    output int                          mismatches, faults
);
    localparam int OUTPUTS = `UDP_RX_OUTPUTS;

    logic [15:0]        tab_m [OUTPUTS];
    logic [OUTPUTS-1:0] en_m;
    logic [79:0]        hdr_q [OUTPUTS][$];  // {src_ip, src_port, dest_port, length}
    logic [8:0]         pay_q [OUTPUTS][$];  // {tlast, tdata}
    int                 deliv_m [OUTPUTS];
    int                 drop_m;
    int                 route;               // Output of the frame in flight, -1 when dropped
    int                 exp_cnt;
    logic               rst_prev;
    logic [OUTPUTS-1:0] hdr_prev;

    // Lowest enabled entry holding the port, otherwise drop
    function automatic int route_of(input logic [15:0] port);
        for (int i = 0; i < OUTPUTS; i++) begin
            if (en_m[i] && tab_m[i] == port) return i;
        end
        return -1;
    endfunction

    task automatic compare(input string name, input logic [79:0] exp, input logic [79:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic fault(input string what);
        $display("ERROR: %s", what);
        faults++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            mismatches = 0;
            faults = 0;
            en_m = '0;
            drop_m = 0;
            route = -1;
            for (int i = 0; i < OUTPUTS; i++) begin
                deliv_m[i] = 0;
                hdr_q[i].delete();
                pay_q[i].delete();
            end
        end else begin
            if (!rst_prev) compare("reset_idle", '0, 80'({out_hdr_valid, out_tvalid, in_tready}));
            if (!rx_enable) begin
                compare("disabled_hdr_ready", '0, 80'(in_hdr_ready));
                compare("disabled_new_header", '0, 80'(out_hdr_valid & ~hdr_prev));
            end
            // Input side first, payload can leave in the same cycle it arrives
            if (in_hdr_valid && in_hdr_ready) begin
                route = route_of(in_dest_port);
                if (route < 0) begin
                    drop_m++;
                end else begin
                    hdr_q[route].push_back({in_src_ip, in_src_port, in_dest_port, in_udp_length});
                    deliv_m[route]++;
                end
            end
            if (in_tvalid && in_tready && route >= 0) pay_q[route].push_back({in_tlast, in_tdata});
            // A table write only affects headers after this edge
            if (cfg_wr) begin
                tab_m[cfg_index] = cfg_port;
                en_m[cfg_index] = cfg_en;
            end
            for (int i = 0; i < OUTPUTS; i++) begin
                if (out_hdr_valid[i] && out_hdr_ready[i]) begin
                    if (hdr_q[i].size() == 0) begin
                        fault($sformatf("header on output %0d with no frame routed there", i));
                    end else begin
                        compare($sformatf("header_out%0d", i), hdr_q[i].pop_front(),
                                {out_src_ip, out_src_port, out_dest_port, out_udp_length});
                    end
                end
                if (out_tvalid[i] && out_tready[i]) begin
                    if (pay_q[i].size() == 0) begin
                        fault($sformatf("payload byte on output %0d with no frame routed there",
                                        i));
                    end else begin
                        compare($sformatf("payload_out%0d", i), 80'(pay_q[i].pop_front()),
                                80'({out_tlast, out_tdata}));
                    end
                end
            end
            if (stat_strobe) begin
                exp_cnt = (int'(stat_index) < OUTPUTS) ? deliv_m[stat_index[1:0]] : drop_m;
                compare($sformatf("stat_count_%0d", stat_index), 80'(exp_cnt), 80'(stat_count));
            end
            if (end_check) begin
                for (int i = 0; i < OUTPUTS; i++) begin
                    if (hdr_q[i].size() != 0 || pay_q[i].size() != 0)
                        fault($sformatf("output %0d never delivered %0d headers and %0d bytes",
                                        i, hdr_q[i].size(), pay_q[i].size()));
                end
            end
        end
        rst_prev = rst_n;
        hdr_prev = out_hdr_valid;
    end

endmodule

/* tests/udp_rx_dispatch_tb.sv */
// Random UDP frames through the dispatch stage with random output back-pressure
// Port table: entry 0 alone, entries 1 and 2 share one port, entry 3 disabled
`include "udp_rx_consts.svh"

module udp_rx_dispatch_tb;
    localparam int          OUTPUTS  = `UDP_RX_OUTPUTS;
    localparam int          FRAMES   = 60;
    localparam int          TIMEOUT  = 1000;  // Cycles allowed for any single wait
    localparam logic [15:0] PORT_A   = 16'd53;
    localparam logic [15:0] PORT_B   = 16'd5000;
    localparam logic [15:0] PORT_OFF = 16'd7000;

    logic                       clk = 1'b0;
    logic                       rst_n, rx_enable;
    logic                       cfg_wr, cfg_en;
    logic [`UDP_RX_SEL_W-1:0]   cfg_index;
    logic [`UDP_RX_PORT_W-1:0]  cfg_port;
    logic                       in_hdr_valid, in_hdr_ready;
    logic [31:0]                in_src_ip;
    logic [15:0]                in_src_port, in_dest_port, in_udp_length;
    logic [`UDP_RX_DATA_W-1:0]  in_tdata;
    logic                       in_tvalid, in_tready, in_tlast;
    logic [`UDP_RX_OUTPUTS-1:0] out_hdr_valid, out_tvalid;
    logic [`UDP_RX_OUTPUTS-1:0] out_hdr_ready = '0;
    logic [`UDP_RX_OUTPUTS-1:0] out_tready = '0;
    logic [31:0]                out_src_ip;
    logic [15:0]                out_src_port, out_dest_port, out_udp_length;
    logic [`UDP_RX_DATA_W-1:0]  out_tdata;
    logic                       out_tlast;
    logic [`UDP_RX_SEL_W:0]     stat_index;
    logic [`UDP_RX_CNT_W-1:0]   stat_count;
    logic                       stat_strobe, end_check;
    int                         mismatches, faults;
    int                         seed;

    always #20 clk = ~clk;

    udp_rx_dispatch_top dut (.*);
    udp_rx_checker scoreboard (.*);

    function automatic int rand_below(input int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    // Each sink takes a beat 70 percent of the time
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < OUTPUTS; i++) begin
                out_hdr_ready[i] <= rand_below(100) < 70;
                out_tready[i]    <= rand_below(100) < 70;
            end
        end
    end

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, faults);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR: timed out waiting for %s", what);
        print_counts();
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic write_cfg(input int idx, input logic [15:0] port, input logic en);
        cfg_wr    <= 1'b1;
        cfg_index <= 2'(idx);
        cfg_port  <= port;
        cfg_en    <= en;
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    // Header first, then the payload once the header is taken
    task automatic send_frame(input bit hold_off);
        logic [15:0] port;
        int          len;
        int          gap;
        int          n;
        case (rand_below(8))
            0: port = 16'(rand_below(65536));  // Random miss
            1: port = PORT_OFF;                 // Disabled entry, also a miss
            2, 3, 4: port = PORT_A;
            default: port = PORT_B;
        endcase
        len = 1 + rand_below(16);
        in_hdr_valid  <= 1'b1;
        in_src_ip     <= $random(seed);
        in_src_port   <= 16'(rand_below(65536));
        in_dest_port  <= port;
        in_udp_length <= 16'(len + 8);
        if (hold_off) begin
            rx_enable <= 1'b0;
            repeat (20) @(posedge clk);
            rx_enable <= 1'b1;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_hdr_ready && n < TIMEOUT);
        if (!in_hdr_ready) abort_run("the input header to be accepted");
        in_hdr_valid <= 1'b0;
        for (int b = 0; b < len; b++) begin
            gap = (rand_below(4) == 0) ? 1 + rand_below(2) : 0;
            if (gap > 0) begin
                in_tvalid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_tvalid <= 1'b1;
            in_tdata  <= 8'(rand_below(256));
            in_tlast  <= (b == len - 1);
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!in_tready && n < TIMEOUT);
            if (!in_tready) abort_run("a payload byte to be accepted");
        end
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
    endtask

    // Ready only returns once the last frame is done and its header taken
    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_hdr_ready && n < TIMEOUT);
        if (!in_hdr_ready) abort_run("the dispatch stage to drain");
    endtask

    task automatic check_stats();
        for (int i = 0; i <= OUTPUTS; i++) begin
            stat_index  <= 3'(i);
            stat_strobe <= 1'b1;
            @(posedge clk);
        end
        stat_strobe <= 1'b0;
        end_check   <= 1'b1;
        @(posedge clk);
        end_check <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        seed          = 32'h6c8a;
        rst_n         = 1'b0;
        rx_enable     = 1'b1;
        cfg_wr        = 1'b0;
        cfg_en        = 1'b0;
        cfg_index     = '0;
        cfg_port      = '0;
        in_hdr_valid  = 1'b0;
        in_src_ip     = '0;
        in_src_port   = '0;
        in_dest_port  = '0;
        in_udp_length = '0;
        in_tdata      = '0;
        in_tvalid     = 1'b0;
        in_tlast      = 1'b0;
        stat_index    = '0;
        stat_strobe   = 1'b0;
        end_check     = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        write_cfg(0, PORT_A, 1'b1);
        write_cfg(1, PORT_B, 1'b1);
        write_cfg(2, PORT_B, 1'b1);
        write_cfg(3, PORT_OFF, 1'b0);
        for (int f = 0; f < FRAMES; f++) begin
            send_frame(f == FRAMES / 2);
        end
        wait_idle();
        check_stats();
        print_counts();
        if (mismatches == 0 && faults == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+src
src/udp_rx_pkg.sv
src/udp_port_classifier.sv
src/udp_rx_demux.sv
src/udp_rx_counters.sv
src/udp_rx_dispatch_top.sv
tests/udp_rx_checker.sv
tests/udp_rx_dispatch_tb.sv

/* Makefile */
# Verilator build and run of the dispatch testbench
VERILATOR ?= verilator
TOP       ?= udp_rx_dispatch_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
